// File: filelist.f
verilog/du_pkg.sv
verilog/du_reg_if.sv
verilog/du_bp_if.sv
verilog/du_apb_port.sv
verilog/du_regs.sv
verilog/du_bp_match.sv
verilog/du_top.sv
+incdir+verification
verification/du_tb.sv

// File: verification/du_stimulus.txt
# op name then hex fields: W addr data | R addr exp_data exp_pslverr | E output exp_value
# C pd_pc pd_instr ex_instr ex_memadr mem_ack bu_flush dbg_stall du_exceptions
W rb_ctrl       0000 00000003
R rb_ctrl       0000 00000003 0
W rb_ctrl_clr   0000 00000000
W rb_ie         0002 a5a50f0f
R rb_ie         0002 a5a50f0f 0
E rb_du_ie      du_ie a5a50f0f
W rb_bpdata0    0011 00001000
R rb_bpdata0    0011 00001000 0
W rb_bpctrl0    0010 00000002
R rb_bpctrl0    0010 00000003 0
W rb_bpdata1    0013 00002040
W rb_bpctrl1    0012 00000022
R rb_bpctrl1    0012 00000023 0
C cb_stall      00000000 00000013 00000013 00000000 0 0 1 00000000
W cb_gpr_wr     1005 cafe0005
E cb_we_rf      du_we_rf 1
E cb_addr       du_addr 005
E cb_dato       du_dato cafe0005
C cb_idle       00000000 00000013 00000013 00000000 0 0 1 00000000
E cb_we_rf_end  du_we_rf 0
R cb_gpr_rd     1003 11110001 0
R cb_npc        1200 00000400 0
C cb_flush      00000000 00000013 00000013 00000000 0 1 1 00000000
R cb_npc_flush  1200 00000800 0
R cb_ppc        1201 000003fc 0
C cb_run        00000000 00000013 00000013 00000000 0 0 0 00000000
R cb_err_rd     1003 00000000 1
W cb_err_wr     1005 00000001
E cb_err_we     du_we_rf 0
R cb_bank3      3004 00000000 0
W st_ctrl       0000 00000001
C st_instr      00000100 00a00093 00000013 00000000 0 0 0 00000000
E st_bp_early   dbg_bp 0
C st_idle       00000000 00000013 00000013 00000000 0 0 0 00000000
E st_bp         dbg_bp 1
R st_hit        0001 00000001 0
W br_ctrl       0000 00000002
W br_clr        0001 00000000
C br_instr      00000104 00208463 00000013 00000000 0 0 0 00000000
C br_idle       00000000 00000013 00000013 00000000 0 0 0 00000000
E br_bp         dbg_bp 1
R br_hit        0001 00000002 0
W bp_ctrl_off   0000 00000000
W bp_clr        0001 00000000
C bp_fetch_fl   00001000 00000013 00000013 00000000 0 1 0 00000000
R bp_fl_none    0001 00000000 0
C bp_fetch      00001000 00000013 00000013 00000000 0 0 0 00000000
R bp_fetch_hit  0001 00000010 0
W bp_clr2       0001 00000000
C bp_load       00000000 00000013 0000a283 00002040 1 0 0 00000000
C bp_st_noack   00000000 00000013 0050a023 00002040 0 0 0 00000000
C bp_st_other   00000000 00000013 0050a023 00002044 1 0 0 00000000
R bp_st_none    0001 00000000 0
C bp_store      00000000 00000013 0050a023 00002040 1 0 0 00000000
R bp_st_hit     0001 00000020 0
W hc_clr        0001 00000000
C hc_idle       00000000 00000013 00000013 00000000 0 0 0 00000000
E hc_bp         dbg_bp 0
C hc_idle2      00000000 00000013 00000013 00000000 0 0 0 00000000
E hc_bp2        dbg_bp 0
R hc_hit        0001 00000000 0
C ca_trap       00000000 00000013 00000013 00000000 0 0 0 0000002c
E ca_bp         dbg_bp 1
R ca_trap       0003 00000002 0
C ca_irq        00000000 00000013 00000013 00000000 0 0 0 00280000
R ca_irq        0003 80000003 0

// File: verification/du_tb_checks.svh
/*
 * Debug unit testbench compare tasks and check counters
 */
`ifndef du_tb_checks_svh
`define du_tb_checks_svh

// Totals for the closing line
int checks;
int errors;

// Data words: prdata, du_dato, du_ie
task automatic check_word(input string name, input du_pkg::xlen_t exp,
                          input du_pkg::xlen_t act);
  checks++;
  if (act !== exp)
  begin
    errors++;
    $display("** Error %s: expected %08h, actual %08h", name, exp, act);
  end
endtask

// Single bits: strobes, pslverr, dbg_bp
task automatic check_flag(input string name, input logic exp, input logic act);
  checks++;
  if (act !== exp)
  begin
    errors++;
    $display("** Error %s: expected %b, actual %b", name, exp, act);
  end
endtask

// Core register address
task automatic check_addr(input string name, input du_pkg::du_addr_t exp,
                          input du_pkg::du_addr_t act);
  checks++;
  if (act !== exp)
  begin
    errors++;
    $display("** Error %s: expected %03h, actual %03h", name, exp, act);
  end
endtask

// APB wait states per transfer
task automatic check_count(input string name, input int exp, input int act);
  checks++;
  if (act != exp)
  begin
    errors++;
    $display("** Error %s: expected %0d, actual %0d", name, exp, act);
  end
endtask

`endif

// File: verification/du_tb.sv
/*
 * Debug unit testbench
 * Replays APB and pipeline operations from the stimulus file against du_top
 */
`timescale 1ns/1ps

module du_tb;
  import du_pkg::*;

  logic                  clk;
  logic                  rstn;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  paddr_t                paddr;
  xlen_t                 pwdata;
  xlen_t                 prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  dbg_stall;
  xlen_t                 du_dati_rf;
  xlen_t                 st_csr_rval;
  xlen_t                 id_pc;
  xlen_t                 ex_pc;
  xlen_t                 bu_nxt_pc;
  logic                  bu_flush;
  xlen_t                 pd_pc;
  instr_t                pd_instr;
  instr_t                ex_instr;
  logic [exc_size-1:0]   ex_exception;
  xlen_t                 ex_memadr;
  logic                  mem_ack;
  logic [31:0]           du_exceptions;
  logic                  du_we_rf;
  logic                  du_we_csr;
  logic                  du_we_pc;
  du_addr_t              du_addr;
  xlen_t                 du_dato;
  logic [31:0]           du_ie;
  logic                  dbg_bp;

  // Operation lines, comments stripped
  string lines [$];
  int    cycle_cnt;
  int    cycle_limit;
  logic  loaded;

  `include "du_tb_checks.svh"

  du_top i_dut (
    .clk           (clk),
    .rstn          (rstn),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .dbg_stall     (dbg_stall),
    .du_dati_rf    (du_dati_rf),
    .st_csr_rval   (st_csr_rval),
    .id_pc         (id_pc),
    .ex_pc         (ex_pc),
    .bu_nxt_pc     (bu_nxt_pc),
    .bu_flush      (bu_flush),
    .pd_pc         (pd_pc),
    .pd_instr      (pd_instr),
    .ex_instr      (ex_instr),
    .ex_exception  (ex_exception),
    .ex_memadr     (ex_memadr),
    .mem_ack       (mem_ack),
    .du_exceptions (du_exceptions),
    .du_we_rf      (du_we_rf),
    .du_we_csr     (du_we_csr),
    .du_we_pc      (du_we_pc),
    .du_addr       (du_addr),
    .du_dato       (du_dato),
    .du_ie         (du_ie),
    .dbg_bp        (dbg_bp)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // Watchdog, limit set once the stimulus is loaded
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: run still busy after %0d clock cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Expected responses from the APB rule
  //////////////////////////////////////////////////
  function automatic logic core_bank(input paddr_t addr);
    return (addr[13:12] == bank_gprs) || (addr[13:12] == bank_csrs);
  endfunction

  // One wait state on a stalled core bank
  function automatic int expected_waits(input paddr_t addr);
    return (core_bank(addr) && dbg_stall) ? 1 : 0;
  endfunction

  function automatic logic expected_err(input paddr_t addr);
    return core_bank(addr) && !dbg_stall;
  endfunction

  //////////////////////////////////////////////////
  // Drivers, every operation starts and ends on a falling edge
  //////////////////////////////////////////////////
  task automatic pipeline_idle();
    pd_pc         = '0;
    pd_instr      = instr_nop;
    ex_instr      = instr_nop;
    ex_memadr     = '0;
    mem_ack       = 1'b0;
    du_exceptions = '0;
  endtask

  task automatic apb_xfer(input string name, input logic wr, input paddr_t addr,
                          input xlen_t wdata, output xlen_t rdata, output logic err);
    int waits;
    waits = 0;
    rdata = '0;
    err   = 1'b0;
    // Setup cycle
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    // Completes on the next rising edge once pready is seen here
    while (!pready && waits <= 4)
    begin
      waits++;
      @(negedge clk);
    end
    if (!pready)
    begin
      errors++;
      $display("%s: pready never rose, transfer abandoned", name);
    end
    else
    begin
      rdata = prdata;
      err   = pslverr;
      check_count({name, " wait states"}, expected_waits(addr), waits);
      @(negedge clk);
    end
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input string name, input paddr_t addr, input xlen_t data);
    xlen_t    rdata;
    logic     err;
    logic     core_ok;
    du_addr_t off;
    apb_xfer(name, 1'b1, addr, data, rdata, err);
    check_flag({name, " pslverr"}, expected_err(addr), err);
    // Strobes pulse in the cycle after completion, stalled core only
    core_ok = core_bank(addr) && dbg_stall;
    off     = addr[11:0];
    check_flag({name, " du_we_rf"},
               core_ok && (addr[13:12] == bank_gprs) && (off <= gpr_last), du_we_rf);
    check_flag({name, " du_we_pc"},
               core_ok && (addr[13:12] == bank_gprs) && (off == reg_npc), du_we_pc);
    check_flag({name, " du_we_csr"},
               core_ok && (addr[13:12] == bank_csrs), du_we_csr);
  endtask

  task automatic apb_read(input string name, input paddr_t addr, input xlen_t exp_data,
                          input logic exp_err);
    xlen_t rdata;
    logic  err;
    apb_xfer(name, 1'b0, addr, '0, rdata, err);
    check_word({name, " prdata"}, exp_data, rdata);
    check_flag({name, " pslverr"}, exp_err, err);
  endtask

  // Pipeline fields for one cycle, stall and flush stay as set
  task automatic core_drive(input xlen_t pc, input xlen_t pd_word, input xlen_t ex_word,
                            input xlen_t memadr, input logic ack, input logic flush,
                            input logic stall, input logic [31:0] exc);
    pd_pc         = pc;
    pd_instr      = pd_word;
    ex_instr      = ex_word;
    ex_memadr     = memadr;
    mem_ack       = ack;
    bu_flush      = flush;
    dbg_stall     = stall;
    du_exceptions = exc;
    @(negedge clk);
    pipeline_idle();
  endtask

  // Output sampled now, no time passes
  task automatic expect_output(input string name, input string flag, input xlen_t val);
    if (flag == "dbg_bp")
      check_flag(name, val[0], dbg_bp);
    else if (flag == "du_we_rf")
      check_flag(name, val[0], du_we_rf);
    else if (flag == "du_we_csr")
      check_flag(name, val[0], du_we_csr);
    else if (flag == "du_we_pc")
      check_flag(name, val[0], du_we_pc);
    else if (flag == "du_addr")
      check_addr(name, du_addr_t'(val), du_addr);
    else if (flag == "du_dato")
      check_word(name, val, du_dato);
    else if (flag == "du_ie")
      check_word(name, val, du_ie);
    else
    begin
      errors++;
      $display("%s: no output called %s to check", name, flag);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus file
  //////////////////////////////////////////////////
  task automatic load_stimulus(output logic ok);
    int    fd;
    int    n;
    string line;
    string op;
    ok = 1'b0;
    fd = $fopen("verification/du_stimulus.txt", "r");
    if (fd == 0)
      $display("Could not open verification/du_stimulus.txt for reading");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        // Blank and comment lines dropped
        if (n > 0 && $sscanf(line, "%s", op) == 1 && op.substr(0, 0) != "#")
          lines.push_back(line);
      end
      $fclose(fd);
      ok = (lines.size() > 0);
      if (!ok)
        $display("The stimulus file holds no operations");
    end
  endtask

  task automatic bad_line(input string line);
    errors++;
    $display("Stimulus line could not be parsed: %s", line);
  endtask

  task automatic run_line(input string line);
    string op;
    string name;
    string flag;
    xlen_t v [8];
    int    n;
    n = $sscanf(line, "%s %s", op, name);
    if (op == "W")
    begin
      n = $sscanf(line, "%s %s %h %h", op, name, v[0], v[1]);
      if (n == 4)
        apb_write(name, paddr_t'(v[0]), v[1]);
      else
        bad_line(line);
    end
    else if (op == "R")
    begin
      n = $sscanf(line, "%s %s %h %h %h", op, name, v[0], v[1], v[2]);
      if (n == 5)
        apb_read(name, paddr_t'(v[0]), v[1], v[2][0]);
      else
        bad_line(line);
    end
    else if (op == "C")
    begin
      n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h", op, name,
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
      if (n == 10)
        core_drive(v[0], v[1], v[2], v[3], v[4][0], v[5][0], v[6][0], v[7]);
      else
        bad_line(line);
    end
    else if (op == "E")
    begin
      n = $sscanf(line, "%s %s %s %h", op, name, flag, v[0]);
      if (n == 4)
        expect_output(name, flag, v[0]);
      else
        bad_line(line);
    end
    else
      bad_line(line);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    clk         = 1'b0;
    rstn        = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    dbg_stall   = 1'b0;
    bu_flush    = 1'b0;
    // Core register file and PC values seen by debugger reads
    du_dati_rf  = 32'h1111_0001;
    st_csr_rval = 32'h0000_1800;
    id_pc       = 32'h0000_0400;
    ex_pc       = 32'h0000_03fc;
    bu_nxt_pc   = 32'h0000_0800;
    ex_exception = '0;
    pipeline_idle();
    checks      = 0;
    errors      = 0;
    cycle_cnt   = 0;
    cycle_limit = 1000;
    load_stimulus(loaded);
    if (!loaded)
    begin
      $display("TEST FAILED");
      $finish;
    end
    else
    begin
      // Eight cycles per operation plus reset
      cycle_limit = lines.size() * 8 + 4;
      repeat (4) @(negedge clk);
      rstn = 1'b1;
      foreach (lines[i])
        run_line(lines[i]);
      @(negedge clk);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
        $display("TEST OK");
      else
        $display("TEST FAILED");
      $finish;
    end
  end

endmodule

// File: verilog/du_apb_port.sv
/*
 * Debug unit APB slave
 * Bank decode, core-bank wait state and error, read mux, core write strobes
 */
`timescale 1ns/1ps

module du_apb_port
(
  input  logic              clk,
  input  logic              rstn,
  // APB slave
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  du_pkg::paddr_t    paddr,
  input  du_pkg::xlen_t     pwdata,
  output du_pkg::xlen_t     prdata,
  output logic              pready,
  output logic              pslverr,
  // Core side
  input  logic              dbg_stall,
  input  du_pkg::xlen_t     du_dati_rf,
  input  du_pkg::xlen_t     st_csr_rval,
  input  du_pkg::xlen_t     id_pc,
  input  du_pkg::xlen_t     ex_pc,
  input  du_pkg::xlen_t     bu_nxt_pc,
  input  logic              bu_flush,
  output logic              du_we_rf,
  output logic              du_we_csr,
  output logic              du_we_pc,
  output du_pkg::du_addr_t  du_addr,
  output du_pkg::xlen_t     du_dato,
  // Internal register access
  du_reg_if.port            reg_bus
);
  import du_pkg::*;

  logic [1:0] bank;
  du_addr_t   offset;
  logic       sel_internal;
  logic       sel_gprs;
  logic       sel_csrs;
  logic       setup_ph;
  logic       access_ph;
  logic       xfer_done;
  logic       need_wait;
  logic       core_err;
  logic       core_wr;
  logic [1:0] acc_cnt;
  xlen_t      rd_mux;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  assign bank         = paddr[13:12];
  assign offset       = paddr[11:0];
  assign sel_internal = (bank == bank_internal);
  assign sel_gprs     = (bank == bank_gprs);
  assign sel_csrs     = (bank == bank_csrs);

  assign setup_ph  = psel & ~penable;
  assign access_ph = psel & penable;
  assign xfer_done = access_ph & pready;
  // Core banks only reachable while the core is stalled
  assign need_wait = (sel_gprs | sel_csrs) & dbg_stall;
  assign core_err  = (sel_gprs | sel_csrs) & ~dbg_stall;
  // pslverr still holds this transfer's error flag
  assign core_wr   = xfer_done & pwrite & (sel_gprs | sel_csrs) & ~pslverr;

  // Internal bank, completes at this edge
  assign reg_bus.req   = xfer_done & sel_internal;
  assign reg_bus.we    = pwrite;
  assign reg_bus.addr  = offset;
  assign reg_bus.wdata = pwdata;

  // Access cycles spent in the current transfer
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      acc_cnt <= 2'd0;
    else if (!psel || xfer_done)
      acc_cnt <= 2'd0;
    else if (access_ph && acc_cnt != 2'd3)
      acc_cnt <= acc_cnt + 2'd1;
  end

  //////////////////////////////////////////////////
  // Handshake and read data
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
      prdata  <= '0;
    end
    else if (xfer_done)
    begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end
    else if (setup_ph && !need_wait)
    begin
      // No wait state, error replies read zero
      pready  <= 1'b1;
      pslverr <= core_err;
      prdata  <= core_err ? '0 : rd_mux;
    end
    else if (access_ph && !pready && acc_cnt == 2'd0)
    begin
      // End of the single wait state, core data sampled here
      pready  <= 1'b1;
      pslverr <= core_err;
      prdata  <= core_err ? '0 : rd_mux;
    end
  end

  always_comb
  begin
    rd_mux = '0;
    case (bank)
      bank_internal: rd_mux = reg_bus.rdata;
      bank_gprs:
      begin
        if (offset <= gpr_last)
          rd_mux = du_dati_rf;
        else if (offset == reg_npc)
          rd_mux = bu_flush ? bu_nxt_pc : id_pc;
        else if (offset == reg_ppc)
          rd_mux = ex_pc;
      end
      bank_csrs:     rd_mux = st_csr_rval;
      default:       rd_mux = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Core write strobes
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      du_we_rf  <= 1'b0;
      du_we_csr <= 1'b0;
      du_we_pc  <= 1'b0;
    end
    else
    begin
      du_we_rf  <= core_wr & sel_gprs & (offset <= gpr_last);
      du_we_pc  <= core_wr & sel_gprs & (offset == reg_npc);
      du_we_csr <= core_wr & sel_csrs;
    end
  end

  // Address goes out at setup so the core can answer in the wait state
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      du_addr <= '0;
      du_dato <= '0;
    end
    else
    begin
      if (setup_ph && need_wait)
        du_addr <= offset;
      if (core_wr)
        du_dato <= pwdata;
    end
  end

endmodule

// File: verilog/du_bp_if.sv
/*
 * Breakpoint settings to the match logic, hit events back
 */
`timescale 1ns/1ps

interface du_bp_if;
  import du_pkg::*;

  // Settings from the register block
  logic [breakpoints-1:0] ena;
  bp_cc_t                 cc   [breakpoints];
  xlen_t                  data [breakpoints];
  logic                   step_ena;
  logic                   branch_ena;

  // One-cycle hit events
  logic [breakpoints-1:0] hit;
  logic                   step_hit;
  logic                   branch_hit;

  modport regs
  (
    output ena, cc, data, step_ena, branch_ena,
    input  hit, step_hit, branch_hit
  );

  modport match
  (
    input  ena, cc, data, step_ena, branch_ena,
    output hit, step_hit, branch_hit
  );

endinterface

// File: verilog/du_bp_match.sv
/*
 * Breakpoint match logic
 * Address compares plus single-step and branch break events
 */
`timescale 1ns/1ps

module du_bp_match
(
  du_bp_if.match                       bp_bus,
  input  du_pkg::xlen_t                pd_pc,
  input  du_pkg::instr_t               pd_instr,
  input  du_pkg::instr_t               ex_instr,
  input  logic [du_pkg::exc_size-1:0]  ex_exception,
  input  du_pkg::xlen_t                ex_memadr,
  input  logic                         mem_ack,
  input  logic                         bu_flush
);
  import du_pkg::*;

  logic                   mem_read;
  logic                   mem_write;
  logic [breakpoints-1:0] bp_hit;

  // Every real instruction breaks when stepping
  assign bp_bus.step_hit   = bp_bus.step_ena & (pd_instr.raw != instr_nop);
  assign bp_bus.branch_hit = bp_bus.branch_ena & (pd_instr.f.opcode == opc_branch);

  // Loads and stores that did not trap
  assign mem_read  = ~|ex_exception & (ex_instr.f.opcode == opc_load);
  assign mem_write = ~|ex_exception & (ex_instr.f.opcode == opc_store);

  always_comb
  begin
    for (int n = 0; n < breakpoints; n++)
    begin
      bp_hit[n] = 1'b0;
      if (bp_bus.ena[n])
      begin
        case (bp_bus.cc[n])
          // Fetch address, ignored while the branch unit flushes
          bp_cc_fetch:
            bp_hit[n] = (pd_pc == bp_bus.data[n]) & ~bu_flush;
          bp_cc_ld_adr:
            bp_hit[n] = (ex_memadr == bp_bus.data[n]) & mem_ack & mem_read;
          bp_cc_st_adr:
            bp_hit[n] = (ex_memadr == bp_bus.data[n]) & mem_ack & mem_write;
          bp_cc_ldst_adr:
            bp_hit[n] = (ex_memadr == bp_bus.data[n]) & mem_ack & (mem_read | mem_write);
          default:
            bp_hit[n] = 1'b0;
        endcase
      end
    end
  end

  assign bp_bus.hit = bp_hit;

endmodule

// File: verilog/du_pkg.sv
/*
 * Debug unit package
 * Widths, debug address map, breakpoint codes, opcodes and instruction word
 */
package du_pkg;

  // Data word
  localparam int xlen = 32;
  typedef logic [xlen-1:0] xlen_t;

  // Debug address: 2-bit bank plus 12-bit offset
  typedef logic [13:0] paddr_t;
  typedef logic [11:0] du_addr_t;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////
  localparam logic [1:0] bank_internal = 2'd0;
  localparam logic [1:0] bank_gprs     = 2'd1;
  localparam logic [1:0] bank_csrs     = 2'd2;

  // Internal bank
  localparam du_addr_t reg_ctrl    = 12'h000;
  localparam du_addr_t reg_hit     = 12'h001;
  localparam du_addr_t reg_ie      = 12'h002;
  localparam du_addr_t reg_cause   = 12'h003;
  // Breakpoint n sits at these plus 2*n
  localparam du_addr_t reg_bpctrl0 = 12'h010;
  localparam du_addr_t reg_bpdata0 = 12'h011;

  // GPR bank
  localparam du_addr_t gpr_last    = 12'h01F;
  localparam du_addr_t reg_npc     = 12'h200;
  localparam du_addr_t reg_ppc     = 12'h201;

  //////////////////////////////////////////////////
  // Breakpoints
  //////////////////////////////////////////////////
  localparam int breakpoints = 3;

  typedef logic [2:0] bp_cc_t;
  localparam bp_cc_t bp_cc_fetch    = 3'd0;
  localparam bp_cc_t bp_cc_ld_adr   = 3'd1;
  localparam bp_cc_t bp_cc_st_adr   = 3'd2;
  localparam bp_cc_t bp_cc_ldst_adr = 3'd3;

  // Major opcodes, instr[6:2]
  localparam logic [4:0] opc_branch = 5'h18;
  localparam logic [4:0] opc_load   = 5'h00;
  localparam logic [4:0] opc_store  = 5'h08;

  // addi x0,x0,0
  localparam logic [31:0] instr_nop = 32'h0000_0013;

  // Instruction word, raw or split into fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [24:0] upper;
      logic [4:0]  opcode;
      logic [1:0]  size;
    } f;
  } instr_t;

  // Exception vector from the execute stage
  localparam int exc_size = 12;

endpackage

// File: verilog/du_reg_if.sv
/*
 * Debugger register access path, APB port to register block
 */
`timescale 1ns/1ps

interface du_reg_if;
  import du_pkg::*;

  // Pulse per completed internal-bank transfer
  logic     req;
  logic     we;
  du_addr_t addr;
  xlen_t    wdata;
  // Combinational from addr, sampled by the port
  xlen_t    rdata;

  modport port
  (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport regs
  (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: verilog/du_regs.sv
/*
 * Debug unit register block
 * Control, hit, interrupt enable, cause, breakpoints and halt request
 */
`timescale 1ns/1ps

module du_regs
(
  input  logic        clk,
  input  logic        rstn,
  du_reg_if.regs      reg_bus,
  du_bp_if.regs       bp_bus,
  input  logic [31:0] du_exceptions,
  input  logic        dbg_stall,
  input  logic        bu_flush,
  output logic [31:0] du_ie,
  output logic        dbg_bp
);
  import du_pkg::*;

  logic                   wr_en;
  logic                   step_ena;
  logic                   branch_ena;
  logic                   step_hit;
  logic                   branch_hit;
  logic [breakpoints-1:0] bp_hit;
  logic                   any_hit;
  logic [31:0]            ie;
  xlen_t                  cause;
  xlen_t                  cause_nxt;
  logic                   trap_hit;
  logic [3:0]             exc_idx;
  logic [breakpoints-1:0] bp_ena;
  bp_cc_t                 bp_cc   [breakpoints];
  xlen_t                  bp_data [breakpoints];

  assign wr_en = reg_bus.req & reg_bus.we;

  //////////////////////////////////////////////////
  // Control, hit, interrupt enable
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      step_ena   <= 1'b0;
      branch_ena <= 1'b0;
      ie         <= '0;
    end
    else if (wr_en)
    begin
      if (reg_bus.addr == reg_ctrl)
      begin
        step_ena   <= reg_bus.wdata[0];
        branch_ena <= reg_bus.wdata[1];
      end
      if (reg_bus.addr == reg_ie)
        ie <= reg_bus.wdata[31:0];
    end
  end

  // Sticky hits, debugger write wins over new events
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      step_hit   <= 1'b0;
      branch_hit <= 1'b0;
      bp_hit     <= '0;
    end
    else if (wr_en && reg_bus.addr == reg_hit)
    begin
      step_hit   <= reg_bus.wdata[0];
      branch_hit <= reg_bus.wdata[1];
      bp_hit     <= reg_bus.wdata[4 +: breakpoints];
    end
    else
    begin
      step_hit   <= step_hit | bp_bus.step_hit;
      branch_hit <= branch_hit | bp_bus.branch_hit;
      bp_hit     <= bp_hit | bp_bus.hit;
    end
  end

  //////////////////////////////////////////////////
  // Cause
  //////////////////////////////////////////////////
  // Traps in [15:0] beat interrupts in [31:16]
  assign trap_hit = |du_exceptions[15:0];

  // Lowest set bit wins, loop runs downward
  always_comb
  begin
    exc_idx = 4'd0;
    for (int i = 15; i >= 0; i--)
    begin
      if (trap_hit ? du_exceptions[i] : du_exceptions[16+i])
        exc_idx = 4'(i);
    end
  end

  // Interrupts flagged in the top bit
  assign cause_nxt = {~trap_hit, {(xlen-5){1'b0}}, exc_idx};

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      cause <= '0;
    else if (wr_en && reg_bus.addr == reg_cause)
      cause <= reg_bus.wdata;
    else if (|du_exceptions)
      cause <= cause_nxt;
  end

  //////////////////////////////////////////////////
  // Breakpoint control and data
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      bp_ena <= '0;
      for (int n = 0; n < breakpoints; n++)
      begin
        bp_cc[n]   <= '0;
        bp_data[n] <= '0;
      end
    end
    else if (wr_en)
    begin
      for (int n = 0; n < breakpoints; n++)
      begin
        // Only enable and cc are stored
        if (reg_bus.addr == du_addr_t'(reg_bpctrl0 + 2*n))
        begin
          bp_ena[n] <= reg_bus.wdata[1];
          bp_cc[n]  <= reg_bus.wdata[6:4];
        end
        if (reg_bus.addr == du_addr_t'(reg_bpdata0 + 2*n))
          bp_data[n] <= reg_bus.wdata;
      end
    end
  end

  // Read decode
  always_comb
  begin
    reg_bus.rdata = '0;
    case (reg_bus.addr)
      reg_ctrl:  reg_bus.rdata[1:0] = {branch_ena, step_ena};
      reg_hit:
      begin
        reg_bus.rdata[1:0]              = {branch_hit, step_hit};
        reg_bus.rdata[4 +: breakpoints] = bp_hit;
      end
      reg_ie:    reg_bus.rdata = ie;
      reg_cause: reg_bus.rdata = cause;
      default:   reg_bus.rdata = '0;
    endcase
    for (int n = 0; n < breakpoints; n++)
    begin
      if (reg_bus.addr == du_addr_t'(reg_bpctrl0 + 2*n))
      begin
        // Bit 0 marks the slot as implemented
        reg_bus.rdata[0]   = 1'b1;
        reg_bus.rdata[1]   = bp_ena[n];
        reg_bus.rdata[6:4] = bp_cc[n];
      end
      if (reg_bus.addr == du_addr_t'(reg_bpdata0 + 2*n))
        reg_bus.rdata = bp_data[n];
    end
  end

  // Settings to the match logic
  assign bp_bus.ena        = bp_ena;
  assign bp_bus.cc         = bp_cc;
  assign bp_bus.data       = bp_data;
  assign bp_bus.step_ena   = step_ena;
  assign bp_bus.branch_ena = branch_ena;

  assign du_ie = ie;

  //////////////////////////////////////////////////
  // Halt request
  //////////////////////////////////////////////////
  assign any_hit = step_hit | branch_hit | (|bp_hit);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      dbg_bp <= 1'b0;
    else
      dbg_bp <= ~dbg_stall & ~bu_flush & (any_hit | (|du_exceptions));
  end

endmodule

// File: verilog/du_top.sv
/*
 * Debug unit top level, APB port, registers and match logic
 */
`timescale 1ns/1ps

module du_top
(
  input  logic                        clk,
  input  logic                        rstn,
  // APB slave
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  du_pkg::paddr_t              paddr,
  input  du_pkg::xlen_t               pwdata,
  output du_pkg::xlen_t               prdata,
  output logic                        pready,
  output logic                        pslverr,
  // From the core
  input  logic                        dbg_stall,
  input  du_pkg::xlen_t               du_dati_rf,
  input  du_pkg::xlen_t               st_csr_rval,
  input  du_pkg::xlen_t               id_pc,
  input  du_pkg::xlen_t               ex_pc,
  input  du_pkg::xlen_t               bu_nxt_pc,
  input  logic                        bu_flush,
  input  du_pkg::xlen_t               pd_pc,
  input  du_pkg::instr_t              pd_instr,
  input  du_pkg::instr_t              ex_instr,
  input  logic [du_pkg::exc_size-1:0] ex_exception,
  input  du_pkg::xlen_t               ex_memadr,
  input  logic                        mem_ack,
  input  logic [31:0]                 du_exceptions,
  // To the core
  output logic                        du_we_rf,
  output logic                        du_we_csr,
  output logic                        du_we_pc,
  output du_pkg::du_addr_t            du_addr,
  output du_pkg::xlen_t               du_dato,
  output logic [31:0]                 du_ie,
  output logic                        dbg_bp
);

  du_reg_if reg_bus ();
  du_bp_if  bp_bus ();

  // Debugger side
  du_apb_port i_apb_port (
    .clk         (clk),
    .rstn        (rstn),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .dbg_stall   (dbg_stall),
    .du_dati_rf  (du_dati_rf),
    .st_csr_rval (st_csr_rval),
    .id_pc       (id_pc),
    .ex_pc       (ex_pc),
    .bu_nxt_pc   (bu_nxt_pc),
    .bu_flush    (bu_flush),
    .du_we_rf    (du_we_rf),
    .du_we_csr   (du_we_csr),
    .du_we_pc    (du_we_pc),
    .du_addr     (du_addr),
    .du_dato     (du_dato),
    .reg_bus     (reg_bus.port)
  );

  du_regs i_regs (
    .clk           (clk),
    .rstn          (rstn),
    .reg_bus       (reg_bus.regs),
    .bp_bus        (bp_bus.regs),
    .du_exceptions (du_exceptions),
    .dbg_stall     (dbg_stall),
    .bu_flush      (bu_flush),
    .du_ie         (du_ie),
    .dbg_bp        (dbg_bp)
  );

  // Pipeline side
  du_bp_match i_bp_match (
    .bp_bus       (bp_bus.match),
    .pd_pc        (pd_pc),
    .pd_instr     (pd_instr),
    .ex_instr     (ex_instr),
    .ex_exception (ex_exception),
    .ex_memadr    (ex_memadr),
    .mem_ack      (mem_ack),
    .bu_flush     (bu_flush)
  );

endmodule
